// File: testbench/icache_cases.txt
# op addr hit err, all hex; op 0 is a fetch and op 1 a flush
# the memory model answers SLVERR for 0000f000 to 0000f0ff
0 00000100 0 0
0 00000118 1 0
0 00000108 1 0
0 00001040 0 0
0 00001248 0 0
0 00001050 1 0
0 00001440 0 0
0 00001058 1 0
0 00001240 0 0
0 00001258 1 0
0 80002000 0 0
0 80002000 0 0
0 80002008 0 0
1 00000000 0 0
0 00000110 0 0
0 00000100 1 0
0 00001240 0 0
0 0000f020 0 1
0 0000f020 0 1
0 0000f038 0 1
0 00003000 0 0
0 00003028 0 0
0 00003010 1 0
0 00003038 1 0
0 80003000 0 0
0 00001250 1 0

// File: filelist.f
source/icache_pkg.sv
source/icache_way.sv
source/icache_ctrl.sv
source/icache_axi_refill.sv
source/icache_top.sv
testbench/icache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the instruction cache testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module icache_tb -f filelist.f -o icache_sim &&
  ./obj_dir/icache_sim > sim.log 2>&1
grep -q "SIMULATION PASSED" sim.log && echo "Run passed" || { echo "Run failed, see sim.log"; exit 1; }

// File: testbench/icache_tb.sv
// Instruction cache testbench that replays a cases file against an AXI memory model
`timescale 1ns/10ps

module icache_tb;

  typedef enum logic [3:0] {
    FETCH = 4'h0,
    FLUSH = 4'h1
  } op_e;

  // Memory word for byte address A is A times this constant
  localparam logic [63:0] MEM_MULT = 64'h9E37_79B9_7F4A_7C15;
  localparam logic [31:0] ERR_LO   = 32'h0000_F000;
  localparam logic [31:0] ERR_HI   = 32'h0000_F0FF;
  localparam int          TIMEOUT  = 100;

  logic                                  clk_i = 1'b0;
  logic                                  rst_ni = 1'b0;
  logic                                  req_valid_i = 1'b0;
  logic [icache_pkg::ADDR_WIDTH-1:0]     req_addr_i = '0;
  logic                                  flush_i = 1'b0;
  logic                                  ar_ready_i = 1'b0;
  logic                                  r_valid_i = 1'b0;
  logic [icache_pkg::DATA_WIDTH-1:0]     r_data_i = '0;
  logic                                  r_last_i = 1'b0;
  logic [icache_pkg::AXI_RESP_WIDTH-1:0] r_resp_i = '0;
  logic                                  req_ready_o, resp_valid_o, resp_hit_o, resp_err_o;
  logic                                  miss_o, ar_valid_o;
  logic [icache_pkg::DATA_WIDTH-1:0]     resp_data_o;
  logic [icache_pkg::ADDR_WIDTH-1:0]     ar_addr_o;
  logic [icache_pkg::AXI_LEN_WIDTH-1:0]  ar_len_o;
  logic [31:0]                           lfsr_q = 32'h512e_7a56;
  int                                    n_cases = 0;

  icache_top dut0 (.*);

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  function automatic logic [63:0] mem_word(input logic [31:0] byte_addr);
    logic [63:0] word_addr;
    word_addr = {32'h0, byte_addr[31:3], 3'b000};
    return word_addr * MEM_MULT;
  endfunction

  function automatic logic in_err_window(input logic [31:0] a);
    return (a >= ERR_LO) && (a <= ERR_HI);
  endfunction

  // Two LFSR bits give an AR delay of zero to three cycles
  task automatic draw_delay(output int unsigned delay);
    delay = 0;
    for (int b = 0; b < 2; b++) begin
      delay = (delay << 1) | 32'(lfsr_q[0]);
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at %0t ns", $time);
  endtask

  task automatic check_data(input logic [icache_pkg::DATA_WIDTH-1:0] got,
                            input logic [icache_pkg::DATA_WIDTH-1:0] exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_addr(input logic [icache_pkg::ADDR_WIDTH-1:0] got,
                            input logic [icache_pkg::ADDR_WIDTH-1:0] exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_len(input logic [icache_pkg::AXI_LEN_WIDTH-1:0] got,
                           input logic [icache_pkg::AXI_LEN_WIDTH-1:0] exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (!req_ready_o) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_run("The cache never raised req_ready_o again");
      end
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic run_flush();
    wait_ready();
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
  endtask

  task automatic run_fetch(input logic [31:0] addr, input logic exp_hit, input logic exp_err);
    int                                   cycles;
    int                                   misses;
    int                                   exp_misses;
    int                                   exp_beats;
    logic [icache_pkg::ADDR_WIDTH-1:0]    exp_ar_addr;
    logic [icache_pkg::AXI_LEN_WIDTH-1:0] exp_ar_len;
    exp_misses = (!addr[icache_pkg::NC_BIT] && !exp_hit) ? 1 : 0;
    // A bypass reads one word and a miss reads a whole line
    exp_beats   = addr[icache_pkg::NC_BIT] ? 1 : icache_pkg::LINE_WORDS;
    exp_ar_addr = addr - (addr % (8 * exp_beats));
    exp_ar_len  = icache_pkg::AXI_LEN_WIDTH'(exp_beats - 1);
    wait_ready();
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
    // A hit answers in the cycle right after acceptance
    check_flag(resp_valid_o, exp_hit, "resp_valid_o one cycle after acceptance");
    cycles = 0;
    misses = 0;
    while (!resp_valid_o) begin
      check_flag(req_ready_o, 1'b0, "req_ready_o during a fetch");
      if (miss_o) begin
        misses++;
      end
      if (cycles == 1) begin
        check_flag(ar_valid_o, 1'b1, "ar_valid_o one cycle after the miss");
      end
      if (ar_valid_o) begin
        check_addr(ar_addr_o, exp_ar_addr, "ar_addr_o");
        check_len(ar_len_o, exp_ar_len, "ar_len_o");
      end
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_run($sformatf("No response for the fetch at address %h", addr));
      end
      @(posedge clk_i);
      #1;
    end
    check_flag(resp_hit_o, exp_hit, "resp_hit_o");
    check_flag(resp_err_o, exp_err, "resp_err_o");
    check_flag(misses == exp_misses, 1'b1, "miss_o pulse count matches");
    if (!exp_err) begin
      check_data(resp_data_o, mem_word(addr), "resp_data_o");
    end
  endtask

  // AXI memory serving one burst at a time after a random AR delay
  initial begin : axi_memory
    int unsigned delay;
    logic [31:0] base;
    logic [31:0] beat_addr;
    int          beats;
    forever begin
      @(posedge clk_i);
      #1;
      if (ar_valid_o) begin
        draw_delay(delay);
        base  = ar_addr_o;
        beats = int'(ar_len_o) + 1;
        repeat (delay) begin
          @(posedge clk_i);
          #1;
          check_flag(ar_valid_o, 1'b1, "ar_valid_o under back-pressure");
          check_addr(ar_addr_o, base, "ar_addr_o under back-pressure");
        end
        ar_ready_i = 1'b1;
        @(posedge clk_i);
        #1;
        ar_ready_i = 1'b0;
        for (int i = 0; i < beats; i++) begin
          beat_addr = base + 32'(8 * i);
          r_valid_i = 1'b1;
          r_data_i  = mem_word(beat_addr);
          r_last_i  = (i == beats - 1);
          r_resp_i  = in_err_window(beat_addr) ? 2'b10 : 2'b00;
          @(posedge clk_i);
          #1;
        end
        r_valid_i = 1'b0;
        r_last_i  = 1'b0;
      end
    end
  end

  initial begin : stimulus
    int          fd;
    int          got;
    int          fields;
    string       text;
    logic [31:0] f_op, f_addr, f_hit, f_err;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    fd = $fopen("testbench/icache_cases.txt", "r");
    if (fd == 0) begin
      stop_run("Could not open testbench/icache_cases.txt");
    end
    while (!$feof(fd)) begin
      got = $fgets(text, fd);
      if (got != 0) begin
        // Comment lines do not parse and are skipped
        fields = $sscanf(text, "%h %h %h %h", f_op, f_addr, f_hit, f_err);
        if (fields == 4) begin
          n_cases++;
          case (op_e'(f_op[3:0]))
            FETCH: run_fetch(f_addr, f_hit[0], f_err[0]);
            FLUSH: run_flush();
            default: stop_run("Unknown opcode in the cases file");
          endcase
        end
      end
    end
    $fclose(fd);
    if (n_cases == 0) begin
      stop_run("No operations were read from the cases file");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

// File: source/icache_top.sv
// Instruction cache top level with controller, set-associative ways and AXI refill master
`timescale 1ns/10ps

module icache_top (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // Fetch port
  input  logic                                    req_valid_i,
  input  logic [icache_pkg::ADDR_WIDTH-1:0]       req_addr_i,
  output logic                                    req_ready_o,
  input  logic                                    flush_i,
  output logic                                    resp_valid_o,
  output logic [icache_pkg::DATA_WIDTH-1:0]       resp_data_o,
  output logic                                    resp_hit_o,
  output logic                                    resp_err_o,
  output logic                                    miss_o,
  // AXI read channels
  output logic                                    ar_valid_o,
  output logic [icache_pkg::ADDR_WIDTH-1:0]       ar_addr_o,
  output logic [icache_pkg::AXI_LEN_WIDTH-1:0]    ar_len_o,
  input  logic                                    ar_ready_i,
  input  logic                                    r_valid_i,
  input  logic [icache_pkg::DATA_WIDTH-1:0]       r_data_i,
  input  logic                                    r_last_i,
  input  logic [icache_pkg::AXI_RESP_WIDTH-1:0]   r_resp_i
);

  logic [icache_pkg::NUM_WAYS-1:0]                             way_hit;
  logic [icache_pkg::NUM_WAYS-1:0][icache_pkg::LINE_WIDTH-1:0] way_line;
  logic [icache_pkg::INDEX_BITS-1:0]                           index;
  logic [icache_pkg::TAG_BITS-1:0]                             lookup_tag;
  logic [icache_pkg::NUM_WAYS-1:0]                             way_we;
  logic [icache_pkg::TAG_BITS-1:0]                             fill_tag;
  logic [icache_pkg::LINE_WIDTH-1:0]                           fill_line;
  logic                                                        way_flush;

  logic                                                        miss_req;
  logic [icache_pkg::ADDR_WIDTH-1:0]                           miss_addr;
  logic                                                        miss_nc;
  logic                                                        refill_done;
  logic [icache_pkg::LINE_WIDTH-1:0]                           refill_line;
  logic                                                        refill_err;

  icache_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_addr_i    (req_addr_i),
    .req_ready_o   (req_ready_o),
    .flush_i       (flush_i),
    .resp_valid_o  (resp_valid_o),
    .resp_data_o   (resp_data_o),
    .resp_hit_o    (resp_hit_o),
    .resp_err_o    (resp_err_o),
    .miss_o        (miss_o),
    .way_hit_i     (way_hit),
    .way_line_i    (way_line),
    .index_o       (index),
    .lookup_tag_o  (lookup_tag),
    .way_we_o      (way_we),
    .fill_tag_o    (fill_tag),
    .fill_line_o   (fill_line),
    .way_flush_o   (way_flush),
    .miss_req_o    (miss_req),
    .miss_addr_o   (miss_addr),
    .miss_nc_o     (miss_nc),
    .refill_done_i (refill_done),
    .refill_line_i (refill_line),
    .refill_err_i  (refill_err)
  );

  // One way per slice of the hit and line buses
  for (genvar w = 0; w < icache_pkg::NUM_WAYS; w++) begin : g_way
    icache_way u_way (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .index_i      (index),
      .lookup_tag_i (lookup_tag),
      .we_i         (way_we[w]),
      .fill_tag_i   (fill_tag),
      .fill_line_i  (fill_line),
      .flush_i      (way_flush),
      .hit_o        (way_hit[w]),
      .line_o       (way_line[w])
    );
  end

  icache_axi_refill u_refill (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .miss_req_i    (miss_req),
    .miss_addr_i   (miss_addr),
    .miss_nc_i     (miss_nc),
    .refill_done_o (refill_done),
    .refill_line_o (refill_line),
    .refill_err_o  (refill_err),
    .ar_valid_o    (ar_valid_o),
    .ar_addr_o     (ar_addr_o),
    .ar_len_o      (ar_len_o),
    .ar_ready_i    (ar_ready_i),
    .r_valid_i     (r_valid_i),
    .r_data_i      (r_data_i),
    .r_last_i      (r_last_i),
    .r_resp_i      (r_resp_i)
  );

endmodule

// File: source/icache_axi_refill.sv
// AXI4 read-burst master that fetches cache lines and bypass words for the instruction cache
`timescale 1ns/10ps

module icache_axi_refill (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // Request from the controller
  input  logic                                    miss_req_i,
  input  logic [icache_pkg::ADDR_WIDTH-1:0]       miss_addr_i,
  input  logic                                    miss_nc_i,
  // Return to the controller
  output logic                                    refill_done_o,
  output logic [icache_pkg::LINE_WIDTH-1:0]       refill_line_o,
  output logic                                    refill_err_o,
  // AXI read address channel
  output logic                                    ar_valid_o,
  output logic [icache_pkg::ADDR_WIDTH-1:0]       ar_addr_o,
  output logic [icache_pkg::AXI_LEN_WIDTH-1:0]    ar_len_o,
  input  logic                                    ar_ready_i,
  // AXI read data channel, always accepted
  input  logic                                    r_valid_i,
  input  logic [icache_pkg::DATA_WIDTH-1:0]       r_data_i,
  input  logic                                    r_last_i,
  input  logic [icache_pkg::AXI_RESP_WIDTH-1:0]   r_resp_i
);

  logic                                 ar_valid_q;
  logic [icache_pkg::ADDR_WIDTH-1:0]    ar_addr_q;
  logic [icache_pkg::AXI_LEN_WIDTH-1:0] ar_len_q;
  logic [icache_pkg::ADDR_WIDTH-1:0]    aligned_addr;

  logic [icache_pkg::LINE_WIDTH-1:0]    line_q, line_d;
  logic                                 first_q;
  logic                                 done_q;
  logic                                 err_q;
  logic                                 beat_err;

  // Line aligned for a miss, word aligned for a bypass
  always_comb begin
    if (miss_nc_i) begin
      aligned_addr = {miss_addr_i[icache_pkg::ADDR_WIDTH-1:icache_pkg::BYTE_OFF_BITS],
                      {icache_pkg::BYTE_OFF_BITS{1'b0}}};
    end else begin
      aligned_addr = {miss_addr_i[icache_pkg::ADDR_WIDTH-1:icache_pkg::OFFSET_BITS],
                      {icache_pkg::OFFSET_BITS{1'b0}}};
    end
  end

  // Address request, held until the slave takes it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ar_valid_q <= 1'b0;
      ar_addr_q  <= '0;
      ar_len_q   <= '0;
    end else if (miss_req_i) begin
      ar_valid_q <= 1'b1;
      ar_addr_q  <= aligned_addr;
      ar_len_q   <= miss_nc_i ? '0 : icache_pkg::AXI_LEN_WIDTH'(icache_pkg::LINE_WORDS - 1);
    end else if (ar_valid_q && ar_ready_i) begin
      ar_valid_q <= 1'b0;
    end
  end

  assign ar_valid_o = ar_valid_q;
  assign ar_addr_o  = ar_addr_q;
  assign ar_len_o   = ar_len_q;

  // Beats enter at the top and move down toward word zero
  always_comb begin
    line_d = line_q;
    if (r_valid_i) begin
      line_d = {r_data_i, line_q[icache_pkg::LINE_WIDTH-1:icache_pkg::DATA_WIDTH]};
      // Single beat transfer lands at word zero
      if (first_q && r_last_i) begin
        line_d[icache_pkg::DATA_WIDTH-1:0] = r_data_i;
      end
    end
  end

  assign beat_err = r_valid_i && (r_resp_i != icache_pkg::AXI_RESP_OKAY);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_q <= 1'b1;
      done_q  <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      done_q <= r_valid_i && r_last_i;
      if (r_valid_i) begin
        first_q <= r_last_i;
      end
      // Error sticks until the next request
      if (miss_req_i) begin
        err_q <= 1'b0;
      end else if (beat_err) begin
        err_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    line_q <= line_d;
  end

  assign refill_done_o = done_q;
  assign refill_line_o = line_q;
  assign refill_err_o  = err_q;

endmodule

// File: source/icache_ctrl.sv
// Instruction cache controller with fetch handshake, hit merge, miss handling, LRU and flush
`timescale 1ns/10ps

module icache_ctrl (
  input  logic                                                      clk_i,
  input  logic                                                      rst_ni,
  // Fetch port
  input  logic                                                      req_valid_i,
  input  logic [icache_pkg::ADDR_WIDTH-1:0]                         req_addr_i,
  output logic                                                      req_ready_o,
  input  logic                                                      flush_i,
  output logic                                                      resp_valid_o,
  output logic [icache_pkg::DATA_WIDTH-1:0]                         resp_data_o,
  output logic                                                      resp_hit_o,
  output logic                                                      resp_err_o,
  output logic                                                      miss_o,
  // Way results
  input  logic [icache_pkg::NUM_WAYS-1:0]                           way_hit_i,
  input  logic [icache_pkg::NUM_WAYS-1:0][icache_pkg::LINE_WIDTH-1:0] way_line_i,
  // Way control
  output logic [icache_pkg::INDEX_BITS-1:0]                         index_o,
  output logic [icache_pkg::TAG_BITS-1:0]                           lookup_tag_o,
  output logic [icache_pkg::NUM_WAYS-1:0]                           way_we_o,
  output logic [icache_pkg::TAG_BITS-1:0]                           fill_tag_o,
  output logic [icache_pkg::LINE_WIDTH-1:0]                         fill_line_o,
  output logic                                                      way_flush_o,
  // Refill master
  output logic                                                      miss_req_o,
  output logic [icache_pkg::ADDR_WIDTH-1:0]                         miss_addr_o,
  output logic                                                      miss_nc_o,
  input  logic                                                      refill_done_i,
  input  logic [icache_pkg::LINE_WIDTH-1:0]                         refill_line_i,
  input  logic                                                      refill_err_i
);

  icache_pkg::ctrl_state_e state_q, state_d;

  logic [icache_pkg::ADDR_WIDTH-1:0]    addr_q;
  logic [icache_pkg::DATA_WIDTH-1:0]    data_q;
  logic                                 err_q;
  logic [icache_pkg::WAY_BITS-1:0]      victim_q, victim_d;
  logic [icache_pkg::WAY_BITS-1:0]      hit_way;
  logic [icache_pkg::WAY_BITS-1:0]      lru_q   [icache_pkg::NUM_SETS];
  logic [icache_pkg::NUM_WAYS-1:0]      filled_q [icache_pkg::NUM_SETS];

  logic [icache_pkg::INDEX_BITS-1:0]    index;
  logic [icache_pkg::WORD_OFF_BITS-1:0] word_off;
  logic [icache_pkg::LINE_WIDTH-1:0]    hit_line;
  logic                                 any_hit;
  logic                                 is_nc;
  logic                                 install;

  // Address fields of the fetch in flight
  assign index    = addr_q[icache_pkg::OFFSET_BITS +: icache_pkg::INDEX_BITS];
  assign word_off = addr_q[icache_pkg::BYTE_OFF_BITS +: icache_pkg::WORD_OFF_BITS];
  assign is_nc    = addr_q[icache_pkg::NC_BIT];

  assign index_o      = index;
  assign lookup_tag_o = addr_q[icache_pkg::ADDR_WIDTH-1 -: icache_pkg::TAG_BITS];
  assign fill_tag_o   = addr_q[icache_pkg::ADDR_WIDTH-1 -: icache_pkg::TAG_BITS];
  assign fill_line_o  = refill_line_i;
  assign miss_addr_o  = addr_q;
  assign miss_nc_o    = is_nc;

  // Merge ways, at most one hit is expected
  always_comb begin
    hit_line = '0;
    hit_way  = '0;
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
      hit_line = hit_line | (way_line_i[w] & {icache_pkg::LINE_WIDTH{way_hit_i[w]}});
      if (way_hit_i[w]) begin
        hit_way = icache_pkg::WAY_BITS'(w);
      end
    end
  end

  assign any_hit = |way_hit_i;

  // Victim is the lowest unfilled way, else the LRU pointer of the set
  always_comb begin
    victim_d = lru_q[index];
    for (int w = icache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (!filled_q[index][w]) begin
        victim_d = icache_pkg::WAY_BITS'(w);
      end
    end
  end

  assign install = (state_q == icache_pkg::REFILL) && refill_done_i && !refill_err_i && !is_nc;

  always_comb begin
    state_d      = state_q;
    req_ready_o  = 1'b0;
    resp_valid_o = 1'b0;
    resp_hit_o   = 1'b0;
    resp_err_o   = 1'b0;
    resp_data_o  = data_q;
    miss_o       = 1'b0;
    miss_req_o   = 1'b0;
    way_we_o     = '0;
    way_flush_o  = 1'b0;
    case (state_q)
      icache_pkg::IDLE: begin
        req_ready_o = 1'b1;
        way_flush_o = flush_i;
        if (req_valid_i) begin
          state_d = icache_pkg::LOOKUP;
        end
      end
      icache_pkg::LOOKUP: begin
        if (is_nc) begin
          miss_req_o = 1'b1;
          state_d    = icache_pkg::REFILL;
        end else if (any_hit) begin
          resp_valid_o = 1'b1;
          resp_hit_o   = 1'b1;
          resp_data_o  = hit_line[word_off*icache_pkg::DATA_WIDTH +: icache_pkg::DATA_WIDTH];
          state_d      = icache_pkg::IDLE;
        end else begin
          miss_o     = 1'b1;
          miss_req_o = 1'b1;
          state_d    = icache_pkg::REFILL;
        end
      end
      icache_pkg::REFILL: begin
        if (refill_done_i) begin
          way_we_o[victim_q] = install;
          state_d            = icache_pkg::RESPOND;
        end
      end
      icache_pkg::RESPOND: begin
        resp_valid_o = 1'b1;
        resp_err_o   = err_q;
        state_d      = icache_pkg::IDLE;
      end
      default: begin
        state_d = icache_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= icache_pkg::IDLE;
      victim_q <= '0;
      err_q    <= 1'b0;
      for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
        lru_q[s]    <= '0;
        filled_q[s] <= '0;
      end
    end else begin
      state_q <= state_d;
      if (way_flush_o) begin
        for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
          filled_q[s] <= '0;
        end
      end
      if (miss_o) begin
        victim_q <= victim_d;
      end
      // Two ways, so pointing away is an inversion
      if ((state_q == icache_pkg::LOOKUP) && !is_nc && any_hit) begin
        lru_q[index] <= ~hit_way;
      end
      if (install) begin
        lru_q[index]              <= ~victim_q;
        filled_q[index][victim_q] <= 1'b1;
      end
      if ((state_q == icache_pkg::REFILL) && refill_done_i) begin
        err_q <= refill_err_i;
      end
    end
  end

  // Fetch address and refill response word
  always_ff @(posedge clk_i) begin
    if (req_ready_o && req_valid_i) begin
      addr_q <= req_addr_i;
    end
    if ((state_q == icache_pkg::REFILL) && refill_done_i) begin
      if (is_nc) begin
        data_q <= refill_line_i[icache_pkg::DATA_WIDTH-1:0];
      end else begin
        data_q <= refill_line_i[word_off*icache_pkg::DATA_WIDTH +: icache_pkg::DATA_WIDTH];
      end
    end
  end

endmodule

// File: source/icache_way.sv
// Instruction cache way holding valid bits, tags and line data per set
`timescale 1ns/10ps

module icache_way (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Lookup side, shared by all ways
  input  logic [icache_pkg::INDEX_BITS-1:0]   index_i,
  input  logic [icache_pkg::TAG_BITS-1:0]     lookup_tag_i,
  // Fill side
  input  logic                                we_i,
  input  logic [icache_pkg::TAG_BITS-1:0]     fill_tag_i,
  input  logic [icache_pkg::LINE_WIDTH-1:0]   fill_line_i,
  input  logic                                flush_i,
  // Lookup result
  output logic                                hit_o,
  output logic [icache_pkg::LINE_WIDTH-1:0]   line_o
);

  logic [icache_pkg::NUM_SETS-1:0]   valid_q;
  logic [icache_pkg::TAG_BITS-1:0]   tag_mem  [icache_pkg::NUM_SETS];
  logic [icache_pkg::LINE_WIDTH-1:0] line_mem [icache_pkg::NUM_SETS];

  // Valid bits, flush wins over a fill in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (we_i) begin
      valid_q[index_i] <= 1'b1;
    end
  end

  // Tag and data arrays
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      tag_mem[index_i]  <= fill_tag_i;
      line_mem[index_i] <= fill_line_i;
    end
  end

  // Combinational read of the indexed set
  assign hit_o  = valid_q[index_i] && (tag_mem[index_i] == lookup_tag_i);
  assign line_o = line_mem[index_i];

endmodule

// File: source/icache_pkg.sv
// Instruction cache package with geometry, address fields, bus constants and controller states
package icache_pkg;

  // Fetch and bus widths
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 64;

  // Cache geometry
  localparam int unsigned LINE_WORDS = 4;
  localparam int unsigned NUM_SETS   = 16;
  localparam int unsigned NUM_WAYS   = 2;
  localparam int unsigned LINE_WIDTH = DATA_WIDTH * LINE_WORDS;
  localparam int unsigned WAY_BITS   = $clog2(NUM_WAYS);

  // Address fields, laid out as tag | index | word offset | byte offset
  localparam int unsigned BYTE_OFF_BITS = $clog2(DATA_WIDTH / 8);
  localparam int unsigned WORD_OFF_BITS = $clog2(LINE_WORDS);
  localparam int unsigned OFFSET_BITS   = BYTE_OFF_BITS + WORD_OFF_BITS;
  localparam int unsigned INDEX_BITS    = $clog2(NUM_SETS);
  localparam int unsigned TAG_BITS      = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;

  // Upper address bit set means the fetch bypasses the cache
  localparam int unsigned NC_BIT = 31;

  // AXI read channel fields
  localparam int unsigned            AXI_LEN_WIDTH  = 8;
  localparam int unsigned            AXI_RESP_WIDTH = 2;
  localparam logic [AXI_RESP_WIDTH-1:0] AXI_RESP_OKAY = 2'b00;

  // Controller states
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    LOOKUP  = 2'd1,
    REFILL  = 2'd2,
    RESPOND = 2'd3
  } ctrl_state_e;

endpackage
